// File: project.f
hw/ex_pkg.sv
hw/alu_branch_unit.sv
hw/mult_unit.sv
hw/flu_writeback.sv
hw/ex_stage.sv
tb/ex_stage_checker.sv
tb/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ex_stage -f project.f -o sim_ex_stage \
    && ./obj_dir/sim_ex_stage | tee /dev/stderr | grep '^>>> PASS$' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/tb_ex_stage.sv
// Execute stage testbench
module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import ex_pkg::*;

    localparam int unsigned NUM_INSTR   = 3000;
    localparam int unsigned MAX_CYCLES  = 20000;
    localparam int unsigned DRAIN_LIMIT = 40;

    typedef struct {
        int unsigned due;
        fu_result_t  res;
    } exp_result_t;

    typedef struct {
        int unsigned due;
        bp_resolve_t bp;
    } exp_resolve_t;

    logic            clk_i;
    logic            rst_ni;
    logic            flush_i;
    logic            issue_valid_i;
    fu_data_t        fu_data_i;
    branch_predict_t branch_predict_i;
    logic            issue_ready_o;
    fu_result_t      flu_result_o;
    bp_resolve_t     resolved_branch_o;

    exp_result_t              res_q[$];
    exp_resolve_t             bp_q[$];
    logic                     exp_ready;
    logic                     hold;
    logic [TRANS_ID_BITS-1:0] next_id;
    int unsigned              cycle;
    int unsigned              accepted;

    ex_stage u_ex_stage (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush_i),
        .issue_valid_i     (issue_valid_i),
        .fu_data_i         (fu_data_i),
        .branch_predict_i  (branch_predict_i),
        .issue_ready_o     (issue_ready_o),
        .flu_result_o      (flu_result_o),
        .resolved_branch_o (resolved_branch_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic check_value(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic report_timeout(string what);
        $display("timeout at %0d ns: %s", $time, what);
        $display(">>> FAIL");
        $fatal(1, "wait timed out");
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic logic [XLEN-1:0] alu_model(fu_op_e op, logic [XLEN-1:0] a,
                                                  logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] a_sext;
        a_sext = {{XLEN{a[XLEN-1]}}, a};
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return XLEN'(a_sext >> b[4:0]);
            SLT:     return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
            SLTU:    return (a < b) ? XLEN'(1) : XLEN'(0);
            default: return XLEN'(0);
        endcase
    endfunction

    function automatic logic branch_taken(fu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        case (op)
            EQ:      return a == b;
            NE:      return a != b;
            LT:      return $signed(a) < $signed(b);
            GE:      return $signed(a) >= $signed(b);
            LTU:     return a < b;
            GEU:     return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    // Operands extended to 64 bits give an exact low product
    function automatic logic [XLEN-1:0] mult_model(fu_op_e op, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] a_ext;
        logic [2*XLEN-1:0] b_ext;
        logic [2*XLEN-1:0] prod;
        a_ext = (op == MULH || op == MULHSU) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        b_ext = (op == MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        prod  = a_ext * b_ext;
        return (op == MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    endfunction

    // Called at the rising edge with the values the DUT samples
    task automatic model_edge();
        exp_result_t     r;
        exp_resolve_t    b;
        logic            taken;
        logic [XLEN-1:0] target;
        hold = issue_valid_i & ~issue_ready_o;
        if (flush_i) begin
            res_q.delete();
            bp_q.delete();
            exp_ready = 1'b1;
        end else if (issue_valid_i && issue_ready_o) begin
            accepted++;
            r.res.valid    = 1'b1;
            r.res.trans_id = fu_data_i.trans_id;
            r.res.ex_valid = 1'b0;
            r.due          = cycle + 1;
            exp_ready      = (fu_data_i.fu != MULT);
            if (fu_data_i.fu == MULT) begin
                r.due = cycle + 2;
                r.res.result = mult_model(fu_data_i.operator, fu_data_i.operand_a,
                                          fu_data_i.operand_b);
            end else if (fu_data_i.fu == BRANCH) begin
                taken  = branch_taken(fu_data_i.operator, fu_data_i.operand_a,
                                      fu_data_i.operand_b);
                target = taken ? fu_data_i.pc + fu_data_i.imm : fu_data_i.pc + XLEN'(4);
                b.due              = cycle;
                b.bp.valid         = 1'b1;
                b.bp.pc            = fu_data_i.pc;
                b.bp.target        = target;
                b.bp.is_taken      = taken;
                b.bp.is_mispredict = (taken != branch_predict_i.predict_taken)
                                   || (taken && branch_predict_i.predict_taken
                                       && target != branch_predict_i.predict_target);
                b.bp.ex_valid      = taken && (target[1:0] != 2'b00);
                bp_q.push_back(b);
                r.res.result   = fu_data_i.pc + XLEN'(4);
                r.res.ex_valid = b.bp.ex_valid;
            end else begin
                r.res.result = alu_model(fu_data_i.operator, fu_data_i.operand_a,
                                         fu_data_i.operand_b);
            end
            res_q.push_back(r);
        end else begin
            exp_ready = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus and checks
    // ------------------------------------------------------------
    task automatic drive_stimulus();
        fu_data_t        d;
        branch_predict_t p;
        flush_i <= ($urandom % 40) == 0;
        if (hold) begin
            // Keep the pending offer until it is taken
        end else if (accepted < NUM_INSTR && ($urandom % 4) != 0) begin
            d.fu = fu_e'($urandom % 3);
            case (d.fu)
                ALU:     d.operator = fu_op_e'($urandom % 10);
                BRANCH:  d.operator = fu_op_e'(10 + $urandom % 7);
                default: d.operator = fu_op_e'(17 + $urandom % 4);
            endcase
            d.operand_a = $urandom;
            // Equal operands now and then for EQ and NE
            d.operand_b = (($urandom % 4) == 0) ? d.operand_a : $urandom;
            d.pc        = $urandom & 32'hffff_fffc;
            d.imm       = (($urandom % 4) == 0) ? $urandom : ($urandom & 32'h0000_0ffc);
            d.trans_id  = next_id;
            next_id     = next_id + 1'b1;
            p.predict_taken  = 1'($urandom % 2);
            p.predict_target = (($urandom % 2) == 0) ? d.pc + d.imm : ($urandom & 32'hffff_fffc);
            issue_valid_i    <= 1'b1;
            fu_data_i        <= d;
            branch_predict_i <= p;
        end else begin
            issue_valid_i <= 1'b0;
        end
    endtask

    task automatic check_outputs();
        logic unit_overlap;
        unit_overlap = u_ex_stage.alu_result.valid & u_ex_stage.mult_result.valid;
        check_value("issue_ready_o", XLEN'(issue_ready_o), XLEN'(exp_ready));
        check_value("unit result overlap", XLEN'(unit_overlap), XLEN'(0));
        if (res_q.size() > 0 && res_q[0].due == cycle) begin
            check_value("flu_result_o.valid", XLEN'(flu_result_o.valid), XLEN'(1));
            check_value("flu_result_o.trans_id", XLEN'(flu_result_o.trans_id),
                        XLEN'(res_q[0].res.trans_id));
            check_value("flu_result_o.result", flu_result_o.result, res_q[0].res.result);
            check_value("flu_result_o.ex_valid", XLEN'(flu_result_o.ex_valid),
                        XLEN'(res_q[0].res.ex_valid));
            void'(res_q.pop_front());
        end else begin
            check_value("flu_result_o.valid", XLEN'(flu_result_o.valid), XLEN'(0));
        end
        if (bp_q.size() > 0 && bp_q[0].due == cycle) begin
            check_value("resolved_branch_o.valid", XLEN'(resolved_branch_o.valid), XLEN'(1));
            check_value("resolved_branch_o.pc", resolved_branch_o.pc, bp_q[0].bp.pc);
            check_value("resolved_branch_o.target", resolved_branch_o.target, bp_q[0].bp.target);
            check_value("resolved_branch_o.is_taken", XLEN'(resolved_branch_o.is_taken),
                        XLEN'(bp_q[0].bp.is_taken));
            check_value("resolved_branch_o.is_mispredict",
                        XLEN'(resolved_branch_o.is_mispredict), XLEN'(bp_q[0].bp.is_mispredict));
            check_value("resolved_branch_o.ex_valid", XLEN'(resolved_branch_o.ex_valid),
                        XLEN'(bp_q[0].bp.ex_valid));
            void'(bp_q.pop_front());
        end else begin
            check_value("resolved_branch_o.valid", XLEN'(resolved_branch_o.valid), XLEN'(0));
        end
    endtask

    task automatic step_cycle();
        @(posedge clk_i);
        cycle++;
        model_edge();
        drive_stimulus();
        @(negedge clk_i);
        check_outputs();
    endtask

    initial begin
        int unsigned wait_cycles;
        void'($urandom(57424));
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        issue_valid_i    = 1'b0;
        fu_data_i        = '0;
        branch_predict_i = '0;
        exp_ready        = 1'b1;
        hold             = 1'b0;
        next_id          = '0;
        cycle            = 0;
        accepted         = 0;

        // Outputs stay quiet through the 10 reset cycles
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_i);
            if (i == 9) begin
                rst_ni <= 1'b1;
            end
            @(negedge clk_i);
            check_value("issue_ready_o", XLEN'(issue_ready_o), XLEN'(1));
            check_value("flu_result_o.valid", XLEN'(flu_result_o.valid), XLEN'(0));
            check_value("resolved_branch_o.valid", XLEN'(resolved_branch_o.valid), XLEN'(0));
        end

        while (accepted < NUM_INSTR) begin
            if (cycle >= MAX_CYCLES) begin
                report_timeout("not all instructions were accepted");
            end
            step_cycle();
        end

        // Drain what is still in flight and watch for strays
        wait_cycles = 0;
        while (res_q.size() != 0 || bp_q.size() != 0 || issue_valid_i) begin
            if (wait_cycles >= DRAIN_LIMIT) begin
                report_timeout("results still outstanding after the last issue");
            end
            wait_cycles++;
            step_cycle();
        end
        for (int i = 0; i < 5; i++) begin
            step_cycle();
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: tb/ex_stage_checker.sv
// Execute stage protocol assertions
module ex_stage_checker (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    flush_i,
    input logic                    issue_valid_i,
    input logic                    issue_ready_i,
    input ex_pkg::fu_data_t        fu_data_i,
    input ex_pkg::fu_result_t      alu_result_i,
    input ex_pkg::fu_result_t      mult_result_i,
    input ex_pkg::fu_result_t      flu_result_i,
    input ex_pkg::bp_resolve_t     resolved_branch_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import ex_pkg::*;

    logic mult_fire;

    // A flush in the same cycle kills the multiply
    assign mult_fire = issue_valid_i & issue_ready_i & (fu_data_i.fu == MULT) & ~flush_i;

    // Only one unit feeds the writeback per cycle
    unit_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(alu_result_i.valid && mult_result_i.valid))
        else $error("ALU and multiplier results valid in the same cycle");

    ready_after_mult: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_fire |=> !issue_ready_i)
        else $error("issue ready stayed high after a multiply was accepted");

    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_ni |=> (!flu_result_i.valid && !resolved_branch_i.valid && issue_ready_i))
        else $error("outputs active while in reset");

endmodule

bind ex_stage ex_stage_checker u_ex_stage_checker (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush_i),
    .issue_valid_i     (issue_valid_i),
    .issue_ready_i     (issue_ready_o),
    .fu_data_i         (fu_data_i),
    .alu_result_i      (alu_result),
    .mult_result_i     (mult_result),
    .flu_result_i      (flu_result_o),
    .resolved_branch_i (resolved_branch_o)
);

// File: hw/ex_stage.sv
// Reduced execute stage
module ex_stage (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    issue_valid_i,
    input  ex_pkg::fu_data_t        fu_data_i,
    input  ex_pkg::branch_predict_t branch_predict_i,
    output logic                    issue_ready_o,
    output ex_pkg::fu_result_t      flu_result_o,
    output ex_pkg::bp_resolve_t     resolved_branch_o
);
    import ex_pkg::*;

    logic       issue_fire;
    logic       alu_valid;
    logic       mult_valid;
    logic       mult_ready;
    fu_result_t alu_result;
    fu_result_t mult_result;

    // ------------------------------------------------------------
    // Issue routing
    // ------------------------------------------------------------
    assign issue_ready_o = mult_ready;
    assign issue_fire    = issue_valid_i & issue_ready_o;
    // ALU takes branches and jumps too
    assign alu_valid     = issue_fire & (fu_data_i.fu != MULT);
    assign mult_valid    = issue_fire & (fu_data_i.fu == MULT);

    alu_branch_unit u_alu_branch_unit (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush_i),
        .valid_i           (alu_valid),
        .fu_data_i         (fu_data_i),
        .branch_predict_i  (branch_predict_i),
        .result_o          (alu_result),
        .resolved_branch_o (resolved_branch_o)
    );

    mult_unit u_mult_unit (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .flush_i   (flush_i),
        .valid_i   (mult_valid),
        .fu_data_i (fu_data_i),
        .ready_o   (mult_ready),
        .result_o  (mult_result)
    );

    // ------------------------------------------------------------
    // Single write port
    // ------------------------------------------------------------
    flu_writeback u_flu_writeback (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .alu_result_i  (alu_result),
        .mult_result_i (mult_result),
        .flu_result_o  (flu_result_o)
    );

endmodule

// File: hw/flu_writeback.sv
// Fixed-latency writeback merge
module flu_writeback (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  ex_pkg::fu_result_t alu_result_i,
    input  ex_pkg::fu_result_t mult_result_i,
    output ex_pkg::fu_result_t flu_result_o
);
    import ex_pkg::*;

    fu_result_t               sel;
    logic                     any_valid;

    logic                     wb_valid_q;
    logic [TRANS_ID_BITS-1:0] wb_trans_id_q;
    logic [XLEN-1:0]          wb_result_q;
    logic                     wb_ex_q;

    // Issue back-pressure keeps the two streams apart
    assign sel       = mult_result_i.valid ? mult_result_i : alu_result_i;
    assign any_valid = alu_result_i.valid | mult_result_i.valid;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wb_valid_q <= 1'b0;
        end else if (flush_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= any_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (any_valid) begin
            wb_trans_id_q <= sel.trans_id;
            wb_result_q   <= sel.result;
            wb_ex_q       <= sel.ex_valid;
        end
    end

    // Scoreboard write port
    assign flu_result_o = '{
        valid:    wb_valid_q,
        trans_id: wb_trans_id_q,
        result:   wb_result_q,
        ex_valid: wb_ex_q
    };

endmodule

// File: hw/mult_unit.sv
// Two-stage pipelined multiplier
module mult_unit (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  logic               valid_i,
    input  ex_pkg::fu_data_t   fu_data_i,
    output logic               ready_o,
    output ex_pkg::fu_result_t result_o
);
    import ex_pkg::*;

    localparam int unsigned PW = 2 * XLEN;

    logic                     a_signed;
    logic                     b_signed;

    // Stage one
    logic                     s1_valid_q;
    logic [XLEN-1:0]          s1_a_q;
    logic [XLEN-1:0]          s1_b_q;
    logic                     s1_a_signed_q;
    logic                     s1_b_signed_q;
    fu_op_e                   s1_op_q;
    logic [TRANS_ID_BITS-1:0] s1_trans_id_q;

    // Extended operands and full product
    logic signed [XLEN:0]     mul_a;
    logic signed [XLEN:0]     mul_b;
    logic signed [PW-1:0]     product;
    logic [XLEN-1:0]          product_sel;

    // Stage two
    logic                     s2_valid_q;
    logic [TRANS_ID_BITS-1:0] s2_trans_id_q;
    logic [XLEN-1:0]          s2_result_q;

    // Sign modes per operator, MUL takes the low half so sign is irrelevant
    assign a_signed = fu_data_i.operator inside {MULH, MULHSU};
    assign b_signed = (fu_data_i.operator == MULH);

    // Stage one holds at most one entry
    assign ready_o = ~s1_valid_q;

    // ------------------------------------------------------------
    // Valid pipeline
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            s1_a_q        <= fu_data_i.operand_a;
            s1_b_q        <= fu_data_i.operand_b;
            s1_a_signed_q <= a_signed;
            s1_b_signed_q <= b_signed;
            s1_op_q       <= fu_data_i.operator;
            s1_trans_id_q <= fu_data_i.trans_id;
        end
    end

    // ------------------------------------------------------------
    // Product and half select
    // ------------------------------------------------------------
    // One extra bit makes every mode a signed multiply
    assign mul_a   = {s1_a_signed_q & s1_a_q[XLEN-1], s1_a_q};
    assign mul_b   = {s1_b_signed_q & s1_b_q[XLEN-1], s1_b_q};
    assign product = PW'(mul_a) * PW'(mul_b);

    assign product_sel = (s1_op_q == MUL) ? product[XLEN-1:0] : product[PW-1:XLEN];

    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            s2_trans_id_q <= s1_trans_id_q;
            s2_result_q   <= product_sel;
        end
    end

    assign result_o = '{
        valid:    s2_valid_q,
        trans_id: s2_trans_id_q,
        result:   s2_result_q,
        ex_valid: 1'b0
    };

endmodule

// File: hw/alu_branch_unit.sv
// Single-cycle ALU and branch unit
module alu_branch_unit (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    valid_i,
    input  ex_pkg::fu_data_t        fu_data_i,
    input  ex_pkg::branch_predict_t branch_predict_i,
    output ex_pkg::fu_result_t      result_o,
    output ex_pkg::bp_resolve_t     resolved_branch_o
);
    import ex_pkg::*;

    logic [XLEN-1:0]          op_a;
    logic [XLEN-1:0]          op_b;
    logic [4:0]               shamt;
    logic                     cmp_signed;
    logic                     less;
    logic                     equal;
    logic                     cmp_res;
    logic [XLEN-1:0]          alu_res;

    logic                     is_branch;
    logic                     taken;
    logic [XLEN-1:0]          pc_plus4;
    logic [XLEN-1:0]          target;
    logic                     mispredict;
    logic                     misaligned;

    // Result register
    logic                     res_valid_q;
    logic [TRANS_ID_BITS-1:0] res_trans_id_q;
    logic [XLEN-1:0]          res_value_q;
    logic                     res_ex_q;

    // Resolve register
    logic                     bp_valid_q;
    logic [XLEN-1:0]          bp_pc_q;
    logic [XLEN-1:0]          bp_target_q;
    logic                     bp_taken_q;
    logic                     bp_mispredict_q;
    logic                     bp_ex_q;

    assign op_a  = fu_data_i.operand_a;
    assign op_b  = fu_data_i.operand_b;
    assign shamt = op_b[4:0];

    // ------------------------------------------------------------
    // ALU and compare
    // ------------------------------------------------------------
    always_comb begin
        // One comparator serves SLT/SLTU and the branches
        cmp_signed = fu_data_i.operator inside {SLT, LT, GE};
        equal      = (op_a == op_b);
        if (cmp_signed) begin
            less = $signed(op_a) < $signed(op_b);
        end else begin
            less = op_a < op_b;
        end

        case (fu_data_i.operator)
            ADD:     alu_res = op_a + op_b;
            SUB:     alu_res = op_a - op_b;
            AND:     alu_res = op_a & op_b;
            OR:      alu_res = op_a | op_b;
            XOR:     alu_res = op_a ^ op_b;
            SLL:     alu_res = op_a << shamt;
            SRL:     alu_res = op_a >> shamt;
            SRA:     alu_res = $signed(op_a) >>> shamt;
            SLT,
            SLTU:    alu_res = {{(XLEN-1){1'b0}}, less};
            default: alu_res = '0;
        endcase

        case (fu_data_i.operator)
            EQ:      cmp_res = equal;
            NE:      cmp_res = ~equal;
            LT,
            LTU:     cmp_res = less;
            GE,
            GEU:     cmp_res = ~less;
            JAL:     cmp_res = 1'b1;
            default: cmp_res = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // Branch resolution
    // ------------------------------------------------------------
    assign is_branch  = (fu_data_i.fu == BRANCH);
    assign taken      = is_branch & cmp_res;
    assign pc_plus4   = fu_data_i.pc + XLEN'(4);
    assign target     = taken ? fu_data_i.pc + fu_data_i.imm : pc_plus4;
    // Wrong direction, or right direction with a wrong target
    assign mispredict = (taken != branch_predict_i.predict_taken)
                      | (taken & branch_predict_i.predict_taken
                         & (target != branch_predict_i.predict_target));
    assign misaligned = taken & (target[1:0] != 2'b00);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_valid_q <= 1'b0;
            bp_valid_q  <= 1'b0;
        end else if (flush_i) begin
            res_valid_q <= 1'b0;
            bp_valid_q  <= 1'b0;
        end else begin
            res_valid_q <= valid_i;
            bp_valid_q  <= valid_i & is_branch;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            res_trans_id_q  <= fu_data_i.trans_id;
            res_value_q     <= is_branch ? pc_plus4 : alu_res;
            res_ex_q        <= misaligned;
            bp_pc_q         <= fu_data_i.pc;
            bp_target_q     <= target;
            bp_taken_q      <= taken;
            bp_mispredict_q <= mispredict;
            bp_ex_q         <= misaligned;
        end
    end

    assign result_o = '{
        valid:    res_valid_q,
        trans_id: res_trans_id_q,
        result:   res_value_q,
        ex_valid: res_ex_q
    };

    assign resolved_branch_o = '{
        valid:         bp_valid_q,
        pc:            bp_pc_q,
        target:        bp_target_q,
        is_taken:      bp_taken_q,
        is_mispredict: bp_mispredict_q,
        ex_valid:      bp_ex_q
    };

endmodule

// File: hw/ex_pkg.sv
// Execute stage shared types
package ex_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    // Data and address width
    localparam int unsigned XLEN = 32;
    // Scoreboard transaction ID
    localparam int unsigned TRANS_ID_BITS = 3;

    // ------------------------------------------------------------
    // Unit and operation encodings
    // ------------------------------------------------------------
    // Target unit of an issued instruction
    typedef enum logic [1:0] {
        ALU,
        BRANCH,
        MULT
    } fu_e;

    typedef enum logic [4:0] {
        // Integer ALU
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        // Conditional branch compares
        EQ,
        NE,
        LT,
        GE,
        LTU,
        GEU,
        // Unconditional jump
        JAL,
        // Multiplier
        MUL,
        MULH,
        MULHSU,
        MULHU
    } fu_op_e;

    // ------------------------------------------------------------
    // Records
    // ------------------------------------------------------------
    // One instruction on the issue port
    typedef struct packed {
        fu_e                      fu;
        fu_op_e                   operator;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [XLEN-1:0]          imm;
        logic [XLEN-1:0]          pc;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // Frontend prediction sent along with a branch
    typedef struct packed {
        logic            predict_taken;
        logic [XLEN-1:0] predict_target;
    } branch_predict_t;

    // Resolved branch back to the frontend
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        logic            is_taken;
        logic            is_mispredict;
        // Misaligned fetch target
        logic            ex_valid;
    } bp_resolve_t;

    // Scoreboard write-back entry
    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
        logic                     ex_valid;
    } fu_result_t;

endpackage
